/* source/calendar_set_macros.svh */
`ifndef CALENDAR_SET_MACROS_SVH
`define CALENDAR_SET_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Calendar setter widths
////////////////////////////////////////////////////////////////////////////

// Field value width, large enough for a year of 99
`define CS_VALUE_W 7

// One BCD digit
`define CS_DIGIT_W 4

// Seconds, minutes, hours, day, month, year
`define CS_NUM_FIELDS 6

`endif

/* source/calendar_set_pkg.sv */
`default_nettype none

`include "calendar_set_macros.svh"

package calendar_set_pkg;

	// Field select codes, 6 and 7 are not used
	typedef enum logic [2:0] {
		FIELD_SEC   = 3'd0,
		FIELD_MIN   = 3'd1,
		FIELD_HOUR  = 3'd2,
		FIELD_DAY   = 3'd3,
		FIELD_MONTH = 3'd4,
		FIELD_YEAR  = 3'd5
	} field_e;

	typedef enum logic [1:0] {
		STEP_NONE = 2'd0,
		STEP_UP   = 2'd1,
		STEP_DOWN = 2'd2
	} step_op_e;

	// One-cycle step pulse from the decoder
	typedef struct packed {
		field_e   field;
		step_op_e op;
	} step_cmd_t;

	// Readout word, tens digit above ones digit
	typedef struct packed {
		field_e                  field;
		logic [`CS_DIGIT_W-1:0] tens;
		logic [`CS_DIGIT_W-1:0] ones;
	} readout_t;

endpackage

`default_nettype wire

/* source/set_step_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calendar_set_macros.svh"

module set_step_decoder
	import calendar_set_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  field_e    sel,
	input  logic      btn_up,
	input  logic      btn_down,
	input  logic      busy,
	output step_cmd_t step
);

	logic      btn_up_q;
	logic      btn_down_q;
	logic      up_edge;
	logic      down_edge;
	logic      sel_ok;
	step_cmd_t step_next;

	////////////////////////////////////////////////////////////////////////////
	// Button edge detection
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			btn_up_q   <= 1'b0;
			btn_down_q <= 1'b0;
		end else begin
			btn_up_q   <= btn_up;
			btn_down_q <= btn_down;
		end
	end

	assign up_edge   = btn_up & ~btn_up_q;
	assign down_edge = btn_down & ~btn_down_q;

	// Codes 6 and 7 select nothing
	assign sel_ok = (int'(sel) < `CS_NUM_FIELDS);

	////////////////////////////////////////////////////////////////////////////
	// Step command
	////////////////////////////////////////////////////////////////////////////

	// A pending pulse also blocks, busy only rises one cycle later
	always_comb begin
		step_next.field = sel;
		step_next.op    = STEP_NONE;
		if (sel_ok && !busy && (step.op == STEP_NONE)) begin
			if (up_edge) begin
				step_next.op = STEP_UP;
			end else if (down_edge) begin
				step_next.op = STEP_DOWN;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			step.field <= FIELD_SEC;
			step.op    <= STEP_NONE;
		end else begin
			step <= step_next;
		end
	end

endmodule

`default_nettype wire

/* source/field_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calendar_set_macros.svh"

module field_counter
	import calendar_set_pkg::*;
#(
	parameter field_e FIELD_ID = FIELD_SEC,
	parameter int     LOW      = 0,
	parameter int     HIGH     = 59
) (
	input  logic                   clk,
	input  logic                   reset,
	input  step_cmd_t              step,
	output logic [`CS_VALUE_W-1:0] value
);

	localparam int W = `CS_VALUE_W;

	localparam logic [W-1:0] LOW_V  = W'(LOW);
	localparam logic [W-1:0] HIGH_V = W'(HIGH);

	logic         hit;
	logic [W-1:0] value_next;

	// Every counter sees the same pulse, only the addressed one moves
	assign hit = (step.field == FIELD_ID);

	always_comb begin
		value_next = value;
		if (hit) begin
			case (step.op)
				STEP_UP: begin
					if (value == HIGH_V) begin
						value_next = LOW_V;
					end else begin
						value_next = value + W'(1);
					end
				end
				STEP_DOWN: begin
					if (value == LOW_V) begin
						value_next = HIGH_V;
					end else begin
						value_next = value - W'(1);
					end
				end
				default: begin
					value_next = value;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			value <= LOW_V;
		end else begin
			value <= value_next;
		end
	end

endmodule

`default_nettype wire

/* source/readout_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calendar_set_macros.svh"

module readout_formatter
	import calendar_set_pkg::*;
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  step_cmd_t                                    step,
	input  logic [`CS_NUM_FIELDS-1:0][`CS_VALUE_W-1:0] values,
	output logic                                         busy,
	output logic                                         readout_valid,
	input  logic                                         readout_ready,
	output readout_t                                     readout
);

	localparam int W  = `CS_VALUE_W;
	localparam int DW = `CS_DIGIT_W;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		CAPTURE = 2'd1,
		HOLD    = 2'd2
	} state_e;

	state_e        state;
	state_e        state_next;
	field_e        field_q;
	logic [W-1:0]  cap_value;
	logic [DW-1:0] tens;
	logic [DW-1:0] ones;

	////////////////////////////////////////////////////////////////////////////
	// Readout FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (step.op != STEP_NONE) begin
					state_next = CAPTURE;
				end
			end
			// Counter has updated by now
			CAPTURE: state_next = HOLD;
			HOLD: begin
				if (readout_ready) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign busy          = (state != IDLE);
	assign readout_valid = (state == HOLD);

	////////////////////////////////////////////////////////////////////////////
	// Binary to BCD and readout register
	////////////////////////////////////////////////////////////////////////////

	assign cap_value = values[field_q];

	// Values stay below 100, so the tens fit one digit
	assign tens = DW'(cap_value / W'(10));
	assign ones = DW'(cap_value % W'(10));

	always_ff @(posedge clk) begin
		if ((state == IDLE) && (step.op != STEP_NONE)) begin
			field_q <= step.field;
		end
		if (state == CAPTURE) begin
			readout.field <= field_q;
			readout.tens  <= tens;
			readout.ones  <= ones;
		end
	end

endmodule

`default_nettype wire

/* source/calendar_set_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calendar_set_macros.svh"

module calendar_set_top
	import calendar_set_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  field_e   sel,
	input  logic     btn_up,
	input  logic     btn_down,
	output logic     readout_valid,
	input  logic     readout_ready,
	output readout_t readout
);

	// Limits per field, indexed by field code
	localparam int FIELD_LOW [`CS_NUM_FIELDS]  = '{0, 0, 0, 1, 1, 0};
	localparam int FIELD_HIGH [`CS_NUM_FIELDS] = '{59, 59, 23, 31, 12, 99};

	step_cmd_t                                  step;
	logic                                       busy;
	logic [`CS_NUM_FIELDS-1:0][`CS_VALUE_W-1:0] values;

	set_step_decoder u_decoder (
		.clk      (clk),
		.reset    (reset),
		.sel      (sel),
		.btn_up   (btn_up),
		.btn_down (btn_down),
		.busy     (busy),
		.step     (step)
	);

	////////////////////////////////////////////////////////////////////////////
	// One counter per calendar field
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `CS_NUM_FIELDS; i++) begin : g_field
		field_counter #(
			.FIELD_ID (field_e'(i)),
			.LOW      (FIELD_LOW[i]),
			.HIGH     (FIELD_HIGH[i])
		) u_counter (
			.clk   (clk),
			.reset (reset),
			.step  (step),
			.value (values[i])
		);
	end

	readout_formatter u_formatter (
		.clk           (clk),
		.reset         (reset),
		.step          (step),
		.values        (values),
		.busy          (busy),
		.readout_valid (readout_valid),
		.readout_ready (readout_ready),
		.readout       (readout)
	);

endmodule

`default_nettype wire

/* verif/calendar_set_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calendar_set_macros.svh"

module calendar_set_checker
	import calendar_set_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input step_cmd_t step,
	input logic      busy,
	input logic      readout_valid,
	input logic      readout_ready,
	input readout_t  readout
);

	int unsigned fail_count = 0;

	a_reset_idle: assert property (@(posedge clk)
		reset |=> (!readout_valid && !busy && (step.op == STEP_NONE)))
	else begin
		$error("readout or step still active after reset");
		fail_count++;
	end

	// Step pulse, then CAPTURE, then HOLD
	a_step_to_valid: assert property (@(posedge clk) disable iff (reset)
		(step.op != STEP_NONE) |=> !readout_valid ##1 readout_valid)
	else begin
		$error("readout_valid did not follow the step by two cycles");
		fail_count++;
	end

	// Covers both a dropped valid and a changing word under back-pressure
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(readout_valid && !readout_ready) |=> (readout_valid && $stable(readout)))
	else begin
		$error("readout changed or valid fell before the transfer");
		fail_count++;
	end

	a_single_step: assert property (@(posedge clk) disable iff (reset)
		busy |-> (step.op == STEP_NONE))
	else begin
		$error("step issued while a readout is in flight");
		fail_count++;
	end

	a_bcd_digits: assert property (@(posedge clk) disable iff (reset)
		readout_valid |-> ((readout.tens <= 4'd9) && (readout.ones <= 4'd9)
			&& (int'(readout.field) < `CS_NUM_FIELDS)))
	else begin
		$error("readout word is not a field code with two BCD digits");
		fail_count++;
	end

endmodule

bind calendar_set_top calendar_set_checker u_checker (
	.clk           (clk),
	.reset         (reset),
	.step          (step),
	.busy          (busy),
	.readout_valid (readout_valid),
	.readout_ready (readout_ready),
	.readout       (readout)
);

`default_nettype wire

/* verif/calendar_set_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calendar_set_macros.svh"

module calendar_set_tb
	import calendar_set_pkg::*;
();

	localparam int TIMEOUT = 20;
	localparam int FIELD_LOW [`CS_NUM_FIELDS]  = '{0, 0, 0, 1, 1, 0};
	localparam int FIELD_HIGH [`CS_NUM_FIELDS] = '{59, 59, 23, 31, 12, 99};

	logic     clk;
	logic     reset;
	field_e   sel;
	logic     btn_up;
	logic     btn_down;
	logic     readout_valid;
	logic     readout_ready;
	readout_t readout;
	integer   seed;
	int       model [`CS_NUM_FIELDS];

	calendar_set_top DUT (
		.clk           (clk),
		.reset         (reset),
		.sel           (sel),
		.btn_up        (btn_up),
		.btn_down      (btn_down),
		.readout_valid (readout_valid),
		.readout_ready (readout_ready),
		.readout       (readout)
	);

	always #10 clk = ~clk;

	task automatic stop_with_errors(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on error");
	endtask

	always @(negedge clk) begin
		if (DUT.u_checker.fail_count != 0) begin
			stop_with_errors($sformatf("%0d checker assertions failed",
				DUT.u_checker.fail_count));
		end
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		for (int f = 0; f < `CS_NUM_FIELDS; f++) begin
			model[f] = FIELD_LOW[f];
		end
	endtask

	// Up wins when both buttons rise together
	function automatic int next_value(input int f, input int v, input bit up);
		if (up) begin
			return (v == FIELD_HIGH[f]) ? FIELD_LOW[f] : v + 1;
		end
		return (v == FIELD_LOW[f]) ? FIELD_HIGH[f] : v - 1;
	endfunction

	task automatic press(input int f, input int up, input int down);
		@(negedge clk);
		sel = field_e'(f[2:0]);
		btn_up = (up != 0);
		btn_down = (down != 0);
		@(negedge clk);
		btn_up = 1'b0;
		btn_down = 1'b0;
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!readout_valid) begin
			if (n == TIMEOUT) begin
				stop_with_errors($sformatf("Timed out waiting for readout_valid at %0t", $time));
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic check_readout(input int f);
		int v;
		v = model[f];
		assert ((readout.field == field_e'(f[2:0])) && (readout.tens == 4'(v / 10))
			&& (readout.ones == 4'(v % 10)))
		else stop_with_errors($sformatf("FAIL %0t: field %0d reads %0d%0d, expected %0d",
			$time, f, readout.tens, readout.ones, v));
	endtask

	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			assert (!readout_valid)
			else stop_with_errors($sformatf("FAIL %0t: unexpected readout_valid", $time));
		end
	endtask

	// One press, a check of the readout and of exactly one transfer
	task automatic step_and_check(input int f, input int up, input int down, input int stall);
		readout_ready = (stall == 0);
		press(f, up, down);
		model[f] = next_value(f, model[f], up != 0);
		wait_valid();
		check_readout(f);
		for (int i = 0; i < stall; i++) begin
			@(negedge clk);
			btn_up = ~btn_up;
		end
		check_readout(f);
		btn_up = 1'b0;
		readout_ready = 1'b1;
		check_idle(3);
	endtask

	initial begin
		int f;
		int dir;
		int stall;
		int wrap_fields [5];
		clk = 1'b0;
		reset = 1'b1;
		sel = FIELD_SEC;
		btn_up = 1'b0;
		btn_down = 1'b0;
		readout_ready = 1'b1;
		seed = 32'h24bd_8473;
		wrap_fields = '{0, 2, 3, 4, 5};
		apply_reset();
		check_idle(2);
		for (f = 0; f < `CS_NUM_FIELDS; f++) begin
			step_and_check(f, 1, 0, 0);
		end
		apply_reset();
		for (f = 0; f < `CS_NUM_FIELDS; f++) begin
			step_and_check(f, 0, 1, 0);
		end
		////////////////////////////////////////////////////////////////////////////
		// Wrap in both directions
		////////////////////////////////////////////////////////////////////////////
		for (int i = 0; i < 5; i++) begin
			f = wrap_fields[i];
			repeat (FIELD_HIGH[f] - FIELD_LOW[f] + 1) step_and_check(f, 1, 0, 0);
			repeat (FIELD_HIGH[f] - FIELD_LOW[f] + 1) step_and_check(f, 0, 1, 0);
		end
		step_and_check(1, 1, 1, 0);
		// Codes 6 and 7 select no field
		press(6, 1, 0);
		check_idle(TIMEOUT);
		press(7, 0, 1);
		check_idle(TIMEOUT);
		// Stall, then a press that shows the dropped edges left the field alone
		step_and_check(2, 1, 0, 6);
		step_and_check(2, 1, 0, 0);
		repeat (40) begin
			f = {$random(seed)} % `CS_NUM_FIELDS;
			dir = {$random(seed)} % 2;
			stall = {$random(seed)} % 4;
			step_and_check(f, dir, 1 - dir, stall);
		end
		if (DUT.u_checker.fail_count != 0) begin
			stop_with_errors($sformatf("%0d checker assertions failed", DUT.u_checker.fail_count));
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/calendar_set_pkg.sv
source/set_step_decoder.sv
source/field_counter.sv
source/readout_formatter.sv
source/calendar_set_top.sv
verif/calendar_set_checker.sv
verif/calendar_set_tb.sv

/* Makefile */
# Verilator build and run of the calendar setter testbench

VERILATOR ?= verilator
TOP       ?= calendar_set_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
